// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [63:0] xword_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [10:0] alu_op_t;      // one-hot by ALU_* position
    typedef logic [1:0]  src1_sel_t;
    typedef logic [4:0]  src2_sel_t;
    typedef logic [6:0]  nextpc_sel_t;
    typedef logic [3:0]  mem_mask_t;    // bit 0 double up to bit 3 byte

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_IMM32  = 7'b0011011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_REG32  = 7'b0111011;

    // alu funct3
    localparam logic [2:0] F3_ADD  = 3'b000;    // add, sub, addi, addw
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;    // srl, sra, srai
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_OR   = 5;
    localparam int ALU_XOR  = 6;
    localparam int ALU_SLL  = 7;
    localparam int ALU_SRL  = 8;
    localparam int ALU_SRA  = 9;
    localparam int ALU_LUI  = 10;

    localparam int SRC1_RS1 = 0;
    localparam int SRC1_PC  = 1;

    localparam int SRC2_RS2  = 0;
    localparam int SRC2_IMMI = 1;
    localparam int SRC2_IMMU = 2;
    localparam int SRC2_FOUR = 3;
    localparam int SRC2_IMMS = 4;

    localparam int NPC_SEQ  = 0;
    localparam int NPC_JAL  = 1;
    localparam int NPC_JALR = 2;
    localparam int NPC_BEQ  = 3;
    localparam int NPC_BNE  = 4;
    localparam int NPC_BLT  = 5;    // blt and bltu
    localparam int NPC_BGE  = 6;    // bge and bgeu

    localparam int IN_DEPTH    = 2;
    localparam int OUT_CREDITS = 4;

endpackage

// ==== hdl/rv_decode.sv ====
module rv_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  rv_pkg::inst_t       in_inst,
    input  rv_pkg::xword_t      in_pc,
    input  rv_pkg::xword_t      in_rs1,
    input  rv_pkg::xword_t      in_rs2,
    input  logic                advance,
    output logic                in_credit,
    output logic                dec_valid,
    output rv_pkg::alu_op_t     dec_alu_op,
    output rv_pkg::src1_sel_t   dec_src1_sel,
    output rv_pkg::src2_sel_t   dec_src2_sel,
    output rv_pkg::nextpc_sel_t dec_nextpc_sel,
    output logic                dec_rf_we,
    output rv_pkg::reg_idx_t    dec_rd,
    output logic                dec_mem_en,
    output logic                dec_mem_wen,
    output rv_pkg::mem_mask_t   dec_mem_mask,
    output logic                dec_word_op,
    output logic                dec_illegal,
    output rv_pkg::xword_t      dec_imm_i,
    output rv_pkg::xword_t      dec_imm_s,
    output rv_pkg::xword_t      dec_imm_u,
    output rv_pkg::xword_t      dec_imm_b,
    output rv_pkg::xword_t      dec_imm_j,
    output rv_pkg::xword_t      dec_pc,
    output rv_pkg::xword_t      dec_rs1,
    output rv_pkg::xword_t      dec_rs2
);
    import rv_pkg::*;

    localparam int PTR_W = $clog2(IN_DEPTH);
    localparam int CNT_W = $clog2(IN_DEPTH + 1);

    inst_t            q_inst [IN_DEPTH];
    xword_t           q_pc   [IN_DEPTH];
    xword_t           q_rs1  [IN_DEPTH];
    xword_t           q_rs2  [IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] q_count;
    logic             pop;

    // fields of the queue head
    wire inst_t inst   = q_inst[rd_ptr];
    wire [6:0]  opcode = inst[6:0];
    wire [2:0]  funct3 = inst[14:12];
    wire [6:0]  funct7 = inst[31:25];

    wire lui_ok   = opcode == OP_LUI;
    wire auipc_ok = opcode == OP_AUIPC;
    wire jal_ok   = opcode == OP_JAL;
    wire jalr_ok  = opcode == OP_JALR && funct3 == 3'b000;
    wire is_br    = opcode == OP_BRANCH;
    wire br_eq    = is_br && funct3 == F3_BEQ;
    wire br_ne    = is_br && funct3 == F3_BNE;
    wire br_lt    = is_br && (funct3 == F3_BLT || funct3 == F3_BLTU);
    wire br_ge    = is_br && (funct3 == F3_BGE || funct3 == F3_BGEU);
    wire br_uns   = funct3 == F3_BLTU || funct3 == F3_BGEU;
    wire br_ok    = br_eq | br_ne | br_lt | br_ge;
    wire load_ok  = opcode == OP_LOAD && funct3 != 3'b111;   // signed and unsigned widths
    wire store_ok = opcode == OP_STORE && !funct3[2];
    wire mem_ok   = load_ok | store_ok;
    wire srai_ok  = funct3 == F3_SR && funct7[6:1] == F7_ALT[6:1];  // funct7[0] is shamt[5]
    wire imm_ok   = opcode == OP_IMM
                    && (funct3 == F3_ADD || funct3 == F3_SLTU || funct3 == F3_AND || srai_ok);
    wire imm32_ok = opcode == OP_IMM32 && funct3 == F3_ADD;
    wire reg_ok   = opcode == OP_REG && (funct7 == F7_BASE
                    || (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR)));
    wire reg32_ok = opcode == OP_REG32 && funct3 == F3_ADD && funct7 == F7_BASE;
    wire arith    = imm_ok | reg_ok;
    wire alt_op   = reg_ok && funct7 == F7_ALT;    // sub or sra
    wire jump     = jal_ok | jalr_ok;
    wire legal    = lui_ok | auipc_ok | jump | br_ok | mem_ok | arith | imm32_ok | reg32_ok;

    // upstream holds a credit per free slot so no full check
    assign pop       = (q_count != '0) && (!dec_valid || advance);
    assign in_credit = pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (in_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            q_count <= q_count + CNT_W'(in_valid) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            q_inst[wr_ptr] <= in_inst;
            q_pc[wr_ptr]   <= in_pc;
            q_rs1[wr_ptr]  <= in_rs1;
            q_rs2[wr_ptr]  <= in_rs2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            dec_valid <= 1'b0;
        else if (!dec_valid || advance)
            dec_valid <= q_count != '0;
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec_alu_op[ALU_ADD]  <= (arith && funct3 == F3_ADD && !alt_op) | auipc_ok | jump
                                    | mem_ok | imm32_ok | reg32_ok;
            dec_alu_op[ALU_SUB]  <= (alt_op && funct3 == F3_ADD) | br_eq | br_ne;
            dec_alu_op[ALU_SLT]  <= (arith && funct3 == F3_SLT) | ((br_lt | br_ge) && !br_uns);
            dec_alu_op[ALU_SLTU] <= (arith && funct3 == F3_SLTU) | ((br_lt | br_ge) && br_uns);
            dec_alu_op[ALU_AND]  <= arith && funct3 == F3_AND;
            dec_alu_op[ALU_OR]   <= arith && funct3 == F3_OR;
            dec_alu_op[ALU_XOR]  <= arith && funct3 == F3_XOR;
            dec_alu_op[ALU_SLL]  <= arith && funct3 == F3_SLL;
            dec_alu_op[ALU_SRL]  <= arith && funct3 == F3_SR && !funct7[5];
            dec_alu_op[ALU_SRA]  <= arith && funct3 == F3_SR && funct7[5];
            dec_alu_op[ALU_LUI]  <= lui_ok;

            dec_src1_sel[SRC1_RS1]  <= arith | imm32_ok | reg32_ok | br_ok | mem_ok;
            dec_src1_sel[SRC1_PC]   <= auipc_ok | jump;    // jumps write pc+4
            dec_src2_sel[SRC2_RS2]  <= reg_ok | reg32_ok | br_ok;
            dec_src2_sel[SRC2_IMMI] <= imm_ok | imm32_ok | load_ok;
            dec_src2_sel[SRC2_IMMU] <= lui_ok | auipc_ok;
            dec_src2_sel[SRC2_FOUR] <= jump;
            dec_src2_sel[SRC2_IMMS] <= store_ok;

            dec_nextpc_sel[NPC_SEQ]  <= legal && !(jump | br_ok);
            dec_nextpc_sel[NPC_JAL]  <= jal_ok;
            dec_nextpc_sel[NPC_JALR] <= jalr_ok;
            dec_nextpc_sel[NPC_BEQ]  <= br_eq;
            dec_nextpc_sel[NPC_BNE]  <= br_ne;
            dec_nextpc_sel[NPC_BLT]  <= br_lt;
            dec_nextpc_sel[NPC_BGE]  <= br_ge;

            dec_rf_we    <= legal && !(br_ok | store_ok);
            dec_rd       <= inst[11:7];
            dec_mem_en   <= mem_ok;
            dec_mem_wen  <= store_ok;
            // funct3[1:0] counts byte up to double
            dec_mem_mask <= mem_ok ? mem_mask_t'(4'b1000 >> funct3[1:0]) : '0;
            dec_word_op  <= imm32_ok | reg32_ok;
            dec_illegal  <= !legal;

            dec_imm_i <= {{52{inst[31]}}, inst[31:20]};
            dec_imm_s <= {{52{inst[31]}}, inst[31:25], inst[11:7]};
            dec_imm_u <= {{32{inst[31]}}, inst[31:12], 12'b0};
            dec_imm_b <= {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            dec_imm_j <= {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            dec_pc    <= q_pc[rd_ptr];
            dec_rs1   <= q_rs1[rd_ptr];
            dec_rs2   <= q_rs2[rd_ptr];
        end
    end

endmodule

// ==== hdl/rv_execute.sv ====
module rv_execute (
    input  logic                clk,
    input  logic                reset,
    input  logic                dec_valid,
    input  rv_pkg::alu_op_t     dec_alu_op,
    input  rv_pkg::src1_sel_t   dec_src1_sel,
    input  rv_pkg::src2_sel_t   dec_src2_sel,
    input  rv_pkg::nextpc_sel_t dec_nextpc_sel,
    input  logic                dec_rf_we,
    input  rv_pkg::reg_idx_t    dec_rd,
    input  logic                dec_mem_en,
    input  logic                dec_mem_wen,
    input  rv_pkg::mem_mask_t   dec_mem_mask,
    input  logic                dec_word_op,
    input  logic                dec_illegal,
    input  rv_pkg::xword_t      dec_imm_i,
    input  rv_pkg::xword_t      dec_imm_s,
    input  rv_pkg::xword_t      dec_imm_u,
    input  rv_pkg::xword_t      dec_imm_b,
    input  rv_pkg::xword_t      dec_imm_j,
    input  rv_pkg::xword_t      dec_pc,
    input  rv_pkg::xword_t      dec_rs1,
    input  rv_pkg::xword_t      dec_rs2,
    input  logic                advance_out,
    output logic                advance,
    output logic                ex_valid,
    output rv_pkg::xword_t      ex_alu_res,
    output rv_pkg::xword_t      ex_next_pc,
    output rv_pkg::xword_t      ex_rs2,
    output rv_pkg::reg_idx_t    ex_rd,
    output logic                ex_rf_we,
    output logic                ex_mem_en,
    output logic                ex_mem_wen,
    output rv_pkg::mem_mask_t   ex_mem_mask,
    output logic                ex_word_op,
    output logic                ex_illegal
);
    import rv_pkg::*;

    xword_t     src1, src2;
    xword_t     alu_res, sra_res;
    xword_t     jalr_sum, next_pc;
    logic [5:0] shamt;
    logic       eq, lt, taken;

    assign src1 = ({64{dec_src1_sel[SRC1_RS1]}} & dec_rs1)
                | ({64{dec_src1_sel[SRC1_PC]}}  & dec_pc);
    assign src2 = ({64{dec_src2_sel[SRC2_RS2]}}  & dec_rs2)
                | ({64{dec_src2_sel[SRC2_IMMI]}} & dec_imm_i)
                | ({64{dec_src2_sel[SRC2_IMMU]}} & dec_imm_u)
                | ({64{dec_src2_sel[SRC2_FOUR]}} & 64'd4)
                | ({64{dec_src2_sel[SRC2_IMMS]}} & dec_imm_s);

    assign shamt   = dec_word_op ? {1'b0, src2[4:0]} : src2[5:0];
    assign sra_res = $signed(src1) >>> shamt;

    assign alu_res = ({64{dec_alu_op[ALU_ADD]}}  & (src1 + src2))
                   | ({64{dec_alu_op[ALU_SUB]}}  & (src1 - src2))
                   | ({64{dec_alu_op[ALU_SLT]}}  & {63'd0, $signed(src1) < $signed(src2)})
                   | ({64{dec_alu_op[ALU_SLTU]}} & {63'd0, src1 < src2})
                   | ({64{dec_alu_op[ALU_AND]}}  & (src1 & src2))
                   | ({64{dec_alu_op[ALU_OR]}}   & (src1 | src2))
                   | ({64{dec_alu_op[ALU_XOR]}}  & (src1 ^ src2))
                   | ({64{dec_alu_op[ALU_SLL]}}  & (src1 << shamt))
                   | ({64{dec_alu_op[ALU_SRL]}}  & (src1 >> shamt))
                   | ({64{dec_alu_op[ALU_SRA]}}  & sra_res)
                   | ({64{dec_alu_op[ALU_LUI]}}  & src2);

    // branches put sub or slt/sltu through the alu
    assign eq    = alu_res == '0;
    assign lt    = alu_res[0];
    assign taken = (dec_nextpc_sel[NPC_BEQ] && eq) || (dec_nextpc_sel[NPC_BNE] && !eq)
                || (dec_nextpc_sel[NPC_BLT] && lt) || (dec_nextpc_sel[NPC_BGE] && !lt);

    assign jalr_sum = dec_rs1 + dec_imm_i;

    always_comb begin
        next_pc = dec_pc + 64'd4;
        if (dec_nextpc_sel[NPC_JAL])
            next_pc = dec_pc + dec_imm_j;
        else if (dec_nextpc_sel[NPC_JALR])
            next_pc = {jalr_sum[63:1], 1'b0};
        else if (taken)
            next_pc = dec_pc + dec_imm_b;
    end

    assign advance = !ex_valid || advance_out;

    always_ff @(posedge clk) begin
        if (reset)
            ex_valid <= 1'b0;
        else if (advance)
            ex_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (advance && dec_valid) begin
            ex_alu_res  <= alu_res;
            ex_next_pc  <= next_pc;
            ex_rs2      <= dec_rs2;    // store data
            ex_rd       <= dec_rd;
            ex_rf_we    <= dec_rf_we;
            ex_mem_en   <= dec_mem_en;
            ex_mem_wen  <= dec_mem_wen;
            ex_mem_mask <= dec_mem_mask;
            ex_word_op  <= dec_word_op;
            ex_illegal  <= dec_illegal;
        end
    end

endmodule

// ==== hdl/rv_result.sv ====
module rv_result (
    input  logic              clk,
    input  logic              reset,
    input  logic              ex_valid,
    input  rv_pkg::xword_t    ex_alu_res,
    input  rv_pkg::xword_t    ex_next_pc,
    input  rv_pkg::xword_t    ex_rs2,
    input  rv_pkg::reg_idx_t  ex_rd,
    input  logic              ex_rf_we,
    input  logic              ex_mem_en,
    input  logic              ex_mem_wen,
    input  rv_pkg::mem_mask_t ex_mem_mask,
    input  logic              ex_word_op,
    input  logic              ex_illegal,
    input  logic              out_credit,
    output logic              advance_out,
    output logic              out_valid,
    output rv_pkg::reg_idx_t  out_rd,
    output logic              out_rd_we,
    output rv_pkg::xword_t    out_wdata,
    output rv_pkg::xword_t    out_next_pc,
    output logic              out_mem_en,
    output logic              out_mem_wen,
    output rv_pkg::mem_mask_t out_mem_mask,
    output rv_pkg::xword_t    out_mem_addr,
    output rv_pkg::xword_t    out_mem_wdata,
    output logic              out_illegal
);
    import rv_pkg::*;

    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    logic [CRED_W-1:0] credits;
    logic              send;
    xword_t            wdata;

    assign advance_out = credits != '0;
    assign send        = ex_valid && advance_out;

    // addw and addiw results sign extend from bit 31
    assign wdata = ex_word_op ? {{32{ex_alu_res[31]}}, ex_alu_res[31:0]} : ex_alu_res;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits   <= CRED_W'(OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            credits   <= credits - CRED_W'(send) + CRED_W'(out_credit);
            out_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_rd        <= ex_rd;
            out_rd_we     <= ex_rf_we;
            out_wdata     <= wdata;
            out_next_pc   <= ex_next_pc;
            out_mem_en    <= ex_mem_en;
            out_mem_wen   <= ex_mem_wen;
            out_mem_mask  <= ex_mem_mask;
            out_mem_addr  <= ex_alu_res;    // rs1 + imm
            out_mem_wdata <= ex_rs2;
            out_illegal   <= ex_illegal;
        end
    end

endmodule

// ==== hdl/rv_exec_slice.sv ====
module rv_exec_slice (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  rv_pkg::inst_t     in_inst,
    input  rv_pkg::xword_t    in_pc,
    input  rv_pkg::xword_t    in_rs1,
    input  rv_pkg::xword_t    in_rs2,
    output logic              in_credit,
    input  logic              out_credit,
    output logic              out_valid,
    output rv_pkg::reg_idx_t  out_rd,
    output logic              out_rd_we,
    output rv_pkg::xword_t    out_wdata,
    output rv_pkg::xword_t    out_next_pc,
    output logic              out_mem_en,
    output logic              out_mem_wen,
    output rv_pkg::mem_mask_t out_mem_mask,
    output rv_pkg::xword_t    out_mem_addr,
    output rv_pkg::xword_t    out_mem_wdata,
    output logic              out_illegal
);
    import rv_pkg::*;

    // decode to execute
    logic        dec_valid;
    alu_op_t     dec_alu_op;
    src1_sel_t   dec_src1_sel;
    src2_sel_t   dec_src2_sel;
    nextpc_sel_t dec_nextpc_sel;
    reg_idx_t    dec_rd;
    logic        dec_rf_we, dec_mem_en, dec_mem_wen;
    mem_mask_t   dec_mem_mask;
    logic        dec_word_op, dec_illegal;
    xword_t      dec_imm_i, dec_imm_s, dec_imm_u, dec_imm_b, dec_imm_j;
    xword_t      dec_pc, dec_rs1, dec_rs2;
    logic        advance;

    // execute to result
    logic        ex_valid;
    xword_t      ex_alu_res, ex_next_pc, ex_rs2;
    reg_idx_t    ex_rd;
    logic        ex_rf_we, ex_mem_en, ex_mem_wen;
    mem_mask_t   ex_mem_mask;
    logic        ex_word_op, ex_illegal;
    logic        advance_out;

    rv_decode u_decode (.*);

    rv_execute u_execute (.*);

    rv_result u_result (.*);

endmodule

// ==== verif/tb_rv_exec_slice.sv ====
module tb_rv_exec_slice;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_pkg::*;

    localparam int MAX_TESTS = 40;
    localparam int FAST_RECORDS = 8;    // credits returned at once for these

    logic clk = 1'b0;
    logic reset, in_valid, in_credit, out_credit, out_valid;
    inst_t in_inst;
    xword_t in_pc, in_rs1, in_rs2;
    reg_idx_t out_rd;
    logic out_rd_we, out_mem_en, out_mem_wen, out_illegal;
    xword_t out_wdata, out_next_pc, out_mem_addr, out_mem_wdata;
    mem_mask_t out_mem_mask;

    string t_name [MAX_TESTS];
    inst_t t_inst [MAX_TESTS];
    xword_t t_pc [MAX_TESTS], t_rs1 [MAX_TESTS], t_rs2 [MAX_TESTS];
    xword_t t_wdata [MAX_TESTS], t_next_pc [MAX_TESTS], t_addr [MAX_TESTS];
    logic t_rd_we [MAX_TESTS], t_mem_en [MAX_TESTS], t_mem_wen [MAX_TESTS];
    logic t_illegal [MAX_TESTS];
    mem_mask_t t_mask [MAX_TESTS];
    int accept_cycle [MAX_TESTS];
    int n_tests = 0;

    int exp_q [$];
    int due_q [$];
    int cycle = 0;
    int errors = 0;
    int n_seen = 0;
    int outstanding = 0;
    int credit_pulses = 0;
    int since_reset = 0;
    int up_credits;
    logic [31:0] seed = 32'h1da;

    rv_exec_slice dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task add_entry(input string name, input inst_t inst, input xword_t pc, rs1, rs2,
                   input logic rd_we, input xword_t wdata, next_pc,
                   input logic mem_en, mem_wen, input mem_mask_t mask,
                   input xword_t addr, input logic illegal);
        t_name[n_tests]    = name;
        t_inst[n_tests]    = inst;
        t_pc[n_tests]      = pc;
        t_rs1[n_tests]     = rs1;
        t_rs2[n_tests]     = rs2;
        t_rd_we[n_tests]   = rd_we;
        t_wdata[n_tests]   = wdata;
        t_next_pc[n_tests] = next_pc;
        t_mem_en[n_tests]  = mem_en;
        t_mem_wen[n_tests] = mem_wen;
        t_mask[n_tests]    = mask;
        t_addr[n_tests]    = addr;
        t_illegal[n_tests] = illegal;
        n_tests = n_tests + 1;
    endtask

    // rd = x1, pc 0x1000, sequential
    task alu_case(input string name, input inst_t inst, input xword_t rs1, rs2, wdata);
        add_entry(name, inst, 64'h1000, rs1, rs2, 1'b1, wdata, 64'h1004,
                  1'b0, 1'b0, 4'b0, 64'h0, 1'b0);
    endtask

    task flow_case(input string name, input inst_t inst, input xword_t pc, rs1, rs2,
                   input logic rd_we, input xword_t wdata, next_pc);
        add_entry(name, inst, pc, rs1, rs2, rd_we, wdata, next_pc,
                  1'b0, 1'b0, 4'b0, 64'h0, 1'b0);
    endtask

    task mem_case(input string name, input inst_t inst, input xword_t rs1, rs2,
                  input logic wen, input mem_mask_t mask, input xword_t addr);
        add_entry(name, inst, 64'h1000, rs1, rs2, !wen, 64'h0, 64'h1004,
                  1'b1, wen, mask, addr, 1'b0);
    endtask

    task check_val(input int idx, input string field, input logic [63:0] exp, act);
        if (exp !== act) begin
            errors = errors + 1;
            $display("Error %s %s: expected %h, actual %h", t_name[idx], field, exp, act);
        end
    endtask

    task check_record(input int idx);
        check_val(idx, "rd_we", 64'(t_rd_we[idx]), 64'(out_rd_we));
        check_val(idx, "illegal", 64'(t_illegal[idx]), 64'(out_illegal));
        check_val(idx, "mem_en", 64'(t_mem_en[idx]), 64'(out_mem_en));
        check_val(idx, "next_pc", t_next_pc[idx], out_next_pc);
        if (t_rd_we[idx])
            check_val(idx, "rd", 64'd1, 64'(out_rd));
        if (t_rd_we[idx] && !t_mem_en[idx])
            check_val(idx, "wdata", t_wdata[idx], out_wdata);
        if (t_mem_en[idx]) begin
            check_val(idx, "mem_wen", 64'(t_mem_wen[idx]), 64'(out_mem_wen));
            check_val(idx, "mem_mask", 64'(t_mask[idx]), 64'(out_mem_mask));
            check_val(idx, "mem_addr", t_addr[idx], out_mem_addr);
        end
        if (t_mem_wen[idx])
            check_val(idx, "mem_wdata", t_rs2[idx], out_mem_wdata);
    endtask

    task finish_run;
        if (credit_pulses != n_tests) begin
            errors = errors + 1;
            $display("in_credit pulsed %0d times for %0d instructions", credit_pulses, n_tests);
        end
        $display("%0d records checked, %0d errors", n_seen, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    endtask

    initial begin
        int i;
        reset = 1'b1;
        in_valid = 1'b0;
        in_inst = '0;
        in_pc = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        out_credit = 1'b0;
        up_credits = IN_DEPTH;

        alu_case("add", 32'h003100B3, 64'd5, 64'd7, 64'd12);
        alu_case("sub", 32'h403100B3, 64'd5, 64'd7, 64'hFFFFFFFFFFFFFFFE);
        alu_case("slt", 32'h003120B3, 64'hFFFFFFFFFFFFFFFF, 64'd1, 64'd1);
        alu_case("sltu", 32'h003130B3, 64'hFFFFFFFFFFFFFFFF, 64'd1, 64'd0);
        alu_case("and", 32'h003170B3, 64'hF0F0, 64'hFF00, 64'hF000);
        alu_case("or", 32'h003160B3, 64'hF0F0, 64'hFF00, 64'hFFF0);
        alu_case("xor", 32'h003140B3, 64'hF0F0, 64'hFF00, 64'h0FF0);
        alu_case("sll", 32'h003110B3, 64'd1, 64'd63, 64'h8000000000000000);
        alu_case("srl", 32'h003150B3, 64'h8000000000000000, 64'd4, 64'h0800000000000000);
        alu_case("sra", 32'h403150B3, 64'h8000000000000000, 64'd4, 64'hF800000000000000);
        alu_case("addw", 32'h003100BB, 64'h7FFFFFFF, 64'd1, 64'hFFFFFFFF80000000);
        alu_case("addi", 32'hFFF10093, 64'd0, 64'd0, 64'hFFFFFFFFFFFFFFFF);
        alu_case("andi", 32'h0F017093, 64'h1234, 64'd0, 64'h30);
        alu_case("sltiu", 32'h00513093, 64'd3, 64'd0, 64'd1);
        alu_case("srai", 32'h42415093, 64'h8000000000000000, 64'd0, 64'hFFFFFFFFF8000000);
        alu_case("addiw", 32'h0011009B, 64'h17FFFFFFF, 64'd0, 64'hFFFFFFFF80000000);
        alu_case("lui", 32'h800000B7, 64'd0, 64'd0, 64'hFFFFFFFF80000000);
        flow_case("auipc", 32'h00001097, 64'h2000, 64'd0, 64'd0, 1'b1, 64'h3000, 64'h2004);
        flow_case("jal", 32'h100000EF, 64'h3000, 64'd0, 64'd0, 1'b1, 64'h3004, 64'h3100);
        flow_case("jalr", 32'h005100E7, 64'h4000, 64'h5000, 64'd0, 1'b1, 64'h4004, 64'h5004);
        flow_case("beq_taken", 32'h00310863, 64'h100, 64'd9, 64'd9, 1'b0, 64'd0, 64'h110);
        flow_case("beq_not", 32'h00310863, 64'h100, 64'd9, 64'd8, 1'b0, 64'd0, 64'h104);
        flow_case("bne_not", 32'h00311863, 64'h100, 64'd9, 64'd9, 1'b0, 64'd0, 64'h104);
        flow_case("bne_taken", 32'h00311863, 64'h100, 64'd9, 64'd8, 1'b0, 64'd0, 64'h110);
        flow_case("blt_taken", 32'h00314863, 64'h100, '1, 64'd1, 1'b0, 64'd0, 64'h110);
        flow_case("bltu_taken", 32'h00316863, 64'h100, 64'd1, '1, 1'b0, 64'd0, 64'h110);
        flow_case("bltu_not", 32'h00316863, 64'h100, '1, 64'd1, 1'b0, 64'd0, 64'h104);
        flow_case("bge_not", 32'h00315863, 64'h100, '1, 64'd1, 1'b0, 64'd0, 64'h104);
        flow_case("bge_taken", 32'h00315863, 64'h100, 64'd1, '1, 1'b0, 64'd0, 64'h110);
        flow_case("bgeu_taken", 32'h00317863, 64'h100, '1, 64'd1, 1'b0, 64'd0, 64'h110);
        mem_case("ld", 32'h00813083, 64'h1000, 64'd0, 1'b0, 4'b0001, 64'h1008);
        mem_case("lw", 32'h00812083, 64'h1000, 64'd0, 1'b0, 4'b0010, 64'h1008);
        mem_case("lbu", 32'h00814083, 64'h1000, 64'd0, 1'b0, 4'b1000, 64'h1008);
        mem_case("sh", 32'h00311623, 64'h2000, 64'hBEEF, 1'b1, 4'b0100, 64'h200C);
        add_entry("illegal", 32'h0000007F, 64'h1000, 64'd0, 64'd0, 1'b0, 64'd0, 64'h1004,
                  1'b0, 1'b0, 4'b0, 64'h0, 1'b1);

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        i = 0;
        while (i < n_tests) begin
            @(posedge clk);
            if (in_credit)
                up_credits = up_credits + 1;
            if (up_credits > 0) begin
                in_valid <= 1'b1;
                in_inst  <= t_inst[i];
                in_pc    <= t_pc[i];
                in_rs1   <= t_rs1[i];
                in_rs2   <= t_rs2[i];
                up_credits = up_credits - 1;
                accept_cycle[i] = cycle + 1;    // DUT samples on the next edge
                exp_q.push_back(i);
                i = i + 1;
            end else begin
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    end

    always @(posedge clk) begin
        int idx;
        int due;
        out_credit <= 1'b0;
        if (in_credit)
            credit_pulses = credit_pulses + 1;
        if (reset)
            since_reset = 0;
        else if (since_reset < 3)
            since_reset = since_reset + 1;
        if (since_reset < 3 && (out_valid || in_credit)) begin
            errors = errors + 1;
            $display("out_valid or in_credit went high during or right after reset");
        end
        if (out_valid) begin
            outstanding = outstanding + 1;
            if (outstanding > OUT_CREDITS) begin
                errors = errors + 1;
                $display("more than %0d records outstanding downstream", OUT_CREDITS);
            end
            if (exp_q.size() == 0) begin
                errors = errors + 1;
                $display("result record arrived with no instruction pending");
            end else begin
                idx = exp_q.pop_front();
                check_record(idx);
                // out_valid rises after the third edge and is seen one edge later
                if (idx < FAST_RECORDS && cycle - accept_cycle[idx] != 4) begin
                    errors = errors + 1;
                    $display("%s took %0d cycles instead of 3", t_name[idx],
                             cycle - accept_cycle[idx] - 1);
                end
            end
            n_seen = n_seen + 1;
            seed = lcg_next(seed);
            due = (n_seen <= FAST_RECORDS) ? cycle : cycle + int'((seed >> 16) % 6);
            if (due_q.size() > 0 && due < due_q[$])
                due = due_q[$];    // keep returns in order
            due_q.push_back(due);
        end
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            out_credit <= 1'b1;
            outstanding = outstanding - 1;
        end
        if (n_tests > 0 && n_seen == n_tests) begin
            finish_run();
        end else if (cycle >= 16 + n_tests * 12) begin
            $display("timeout with %0d of %0d results missing", n_tests - n_seen, n_tests);
            $display("%0d records checked, %0d errors", n_seen, errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_exec_slice.sv
verif/tb_rv_exec_slice.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_rv_exec_slice -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qF "*** TEST PASSED ***"
